// ==== Bender.yml ====
package:
  name: ir_lcd_rx

dependencies: {}

sources:
  - hdl/ir_rx_pkg.sv
  - hdl/ir_key_if.sv
  - hdl/lcd_char_if.sv
  - hdl/ir_sampler.sv
  - hdl/ir_nec_decoder.sv
  - hdl/key_arbiter.sv
  - hdl/lcd_ctrl.sv
  - hdl/ir_lcd_top.sv
  - target: test
    files:
      - dv/ir_lcd_tb.sv

// ==== dv/ir_lcd_tb.sv ====
`timescale 1ns/1ps

module ir_lcd_tb;
	logic                       clk;
	logic                       arst_n;
	logic [ir_rx_pkg::N_CH-1:0] irda_rxd;       // low = mark
	logic                       lcd_on;
	logic [7:0]                 lcd_data;
	logic                       lcd_en;
	logic                       lcd_rw;
	logic                       lcd_rs;
	logic                       lcd_out_on;
	logic                       new_data_valid;

	logic       wave [ir_rx_pkg::N_CH][2048]; // per-tick levels per channel
	int         wave_len [ir_rx_pkg::N_CH];
	logic [8:0] exp_q [$];                     // {rs, data} still to come
	logic [8:0] cap_q [$];                     // {rs, data} seen on the bus
	logic [8:0] want;
	logic [8:0] got;
	logic       en_q;
	int         ndv_count;                     // new_data_valid pulses seen
	int         exp_ndv;
	int         lcd_chars;                     // chars since last init
	int         errors;
	integer     seed;
	string      test_name;

	ir_lcd_top #(
		.TICK_DIV (4)
	) dut_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.irda_rxd       (irda_rxd),
		.lcd_on         (lcd_on),
		.lcd_data       (lcd_data),
		.lcd_en         (lcd_en),
		.lcd_rw         (lcd_rw),
		.lcd_rs         (lcd_rs),
		.lcd_out_on     (lcd_out_on),
		.new_data_valid (new_data_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	task automatic fail_run(input string msg);
		errors = errors + 1;
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped in test %s", test_name);
	endtask

	task automatic compare_value(input string what, input logic [31:0] exp,
	                             input logic [31:0] act);
		if (exp !== act)
			fail_run($sformatf("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
			                   test_name, what, exp, act));
	endtask

	// character shown for a key code
	function automatic logic [7:0] expected_char(input logic [7:0] cmd);
		if (cmd == 8'h00)
			return 8'h00;
		if (cmd <= 8'h09)
			return 8'h61 + (cmd - 8'h01); // 1 -> 'a'
		return 8'h20;
	endfunction

	task automatic push_init();
		exp_q.push_back({1'b0, 8'h38});
		exp_q.push_back({1'b0, 8'h0C});
		exp_q.push_back({1'b0, 8'h01});
		exp_q.push_back({1'b0, 8'h06});
	endtask

	// model cursor, line address before column 0 of the next line
	task automatic push_char(input logic [7:0] cmd);
		logic [7:0] addr;
		if (lcd_chars != 0 && lcd_chars % ir_rx_pkg::LCD_COLS == 0) begin
			addr = ((lcd_chars / ir_rx_pkg::LCD_COLS) % 2 == 1) ? 8'hC0 : 8'h80;
			exp_q.push_back({1'b0, addr});
		end
		exp_q.push_back({1'b1, expected_char(cmd)});
		lcd_chars = lcd_chars + 1;
		exp_ndv   = exp_ndv + 1;
	endtask

	task automatic add_level(input int ch, input logic lvl, input int ticks);
		for (int i = 0; i < ticks; i++) begin
			wave[ch][wave_len[ch]] = lvl;
			wave_len[ch] = wave_len[ch] + 1;
		end
	endtask

	task automatic build_frame(input int ch, input logic [7:0] addr, input logic [7:0] cmd,
	                           input logic corrupt);
		logic [31:0] word;
		word = {~cmd, cmd, ~addr, addr}; // sent lsb first
		if (corrupt)
			word[24] = ~word[24]; // inverted command byte no longer matches
		add_level(ch, 1'b1, 8);
		add_level(ch, 1'b0, 128); // leader mark, 9 ms
		add_level(ch, 1'b1, 64);  // leader space, 4.5 ms
		for (int b = 0; b < 32; b++) begin
			add_level(ch, 1'b0, 8);
			add_level(ch, 1'b1, word[b] ? 24 : 8);
		end
		add_level(ch, 1'b0, 8); // stop mark
		add_level(ch, 1'b1, 16);
	endtask

	task automatic build_repeat(input int ch);
		add_level(ch, 1'b1, 8);
		add_level(ch, 1'b0, 128);
		add_level(ch, 1'b1, 32); // short space marks a repeat
		add_level(ch, 1'b0, 8);
		add_level(ch, 1'b1, 16);
	endtask

	// all channels play side by side, one level per sample tick
	task automatic play_waves();
		int                         len;
		logic [ir_rx_pkg::N_CH-1:0] lvl;
		len = 0;
		for (int c = 0; c < ir_rx_pkg::N_CH; c++)
			if (wave_len[c] > len)
				len = wave_len[c];
		for (int t = 0; t < len; t++) begin
			for (int c = 0; c < ir_rx_pkg::N_CH; c++)
				lvl[c] = (t < wave_len[c]) ? wave[c][t] : 1'b1;
			@(posedge clk);
			irda_rxd <= lvl;
			repeat (dut_i.TICK_DIV - 1) @(posedge clk);
		end
		for (int c = 0; c < ir_rx_pkg::N_CH; c++)
			wave_len[c] = 0;
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			n = n + 1;
			if (n > limit)
				fail_run($sformatf("timed out waiting for %0d more LCD bytes", exp_q.size()));
		end
		repeat (2) @(posedge clk);
		compare_value("new_data_valid pulses", exp_ndv, ndv_count);
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++)
			@(posedge clk); // stray bytes hit the compare process
		compare_value("new_data_valid pulses", exp_ndv, ndv_count);
	endtask

	task automatic wait_out_on(input logic level);
		int n;
		n = 0;
		while (lcd_out_on !== level) begin
			@(posedge clk);
			n = n + 1;
			if (n > 20)
				fail_run($sformatf("lcd_out_on did not follow lcd_on to %0b", level));
		end
	endtask

	task automatic send_key(input int ch);
		logic [31:0] r;
		logic [7:0]  cmd;
		r   = $random(seed);
		cmd = r[8] ? r[7:0] % 8'd10 : r[7:0]; // mapped and unmapped keys
		push_char(cmd);
		build_frame(ch, r[23:16], cmd, 1'b0);
		play_waves();
		wait_drained(2000);
	endtask

	// bus monitor, panel latches on the enable fall
	always @(posedge clk) begin
		en_q <= lcd_en;
		if (arst_n) begin
			compare_value("lcd_rw", 32'd0, {31'd0, lcd_rw});
			if (en_q && !lcd_en)
				cap_q.push_back({lcd_rs, lcd_data});
			if (new_data_valid)
				ndv_count <= ndv_count + 1;
		end
	end

	always @(negedge clk) begin
		if (cap_q.size() != 0) begin
			got = cap_q.pop_front();
			if (exp_q.size() == 0) begin
				fail_run($sformatf("LCD bus carried byte 0x%0h with rs %0b that no key caused",
				                   got[7:0], got[8]));
			end else begin
				want = exp_q.pop_front();
				compare_value("lcd rs and data", {23'd0, want}, {23'd0, got});
			end
		end
	end

	initial begin
		logic [31:0] r;
		seed      = 83;
		errors    = 0;
		ndv_count = 0;
		exp_ndv   = 0;
		lcd_chars = 0;
		for (int c = 0; c < ir_rx_pkg::N_CH; c++)
			wave_len[c] = 0;
		test_name = "init";
		arst_n    = 1'b0;
		irda_rxd  = '1; // idle lines
		lcd_on    = 1'b1;
		push_init();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		wait_out_on(1'b1);
		wait_drained(2000);

		test_name = "single";
		repeat (8) send_key(0);

		test_name = "round_robin";
		send_key(3); // pointer moves on to channel 0
		for (int c = 0; c < ir_rx_pkg::N_CH; c++) begin
			r = $random(seed);
			push_char(r[7:0]);
			build_frame(c, r[15:8], r[7:0], 1'b0);
		end
		play_waves(); // valid frames all have the same length
		wait_drained(2000);

		test_name = "corrupt";
		r = $random(seed);
		build_frame(2, r[15:8], r[7:0], 1'b1);
		play_waves();
		expect_quiet(400);

		test_name = "repeat";
		send_key(1);
		build_repeat(1); // inside the hold window of the last frame
		play_waves();
		expect_quiet(400);

		test_name = "line_wrap";
		while (lcd_chars < 2 * ir_rx_pkg::LCD_COLS + 2)
			send_key(0);

		test_name = "power";
		@(posedge clk);
		lcd_on <= 1'b0;
		wait_out_on(1'b0);
		r = $random(seed);
		exp_ndv = exp_ndv + 1; // key still taken, char dropped
		build_frame(0, r[15:8], r[7:0], 1'b0);
		play_waves();
		expect_quiet(400);
		@(posedge clk);
		lcd_on <= 1'b1;
		lcd_chars = 0; // cursor home after init
		push_init();
		wait_out_on(1'b1);
		wait_drained(2000);
		send_key(0);

		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== hdl/ir_key_if.sv ====
`timescale 1ns/1ps

interface ir_key_if;
	logic       valid;     // frame pending
	logic       ready;     // arbiter grant
	logic [7:0] addr;      // nec address byte
	logic [7:0] cmd;       // nec command byte
	logic       is_repeat; // repeat code, fields hold last key

	modport src (
		output valid,
		output addr,
		output cmd,
		output is_repeat,
		input  ready
	);

	modport dst (
		input  valid,
		input  addr,
		input  cmd,
		input  is_repeat,
		output ready
	);
endinterface

// ==== hdl/ir_lcd_top.sv ====
`timescale 1ns/1ps

module ir_lcd_top #(
	parameter int TICK_DIV = 4 // board clock dependent
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [ir_rx_pkg::N_CH-1:0] irda_rxd,      // receiver modules, low = mark
	input  logic                       lcd_on,        // power button
	output logic [7:0]                 lcd_data,
	output logic                       lcd_en,
	output logic                       lcd_rw,
	output logic                       lcd_rs,
	output logic                       lcd_out_on,
	output logic                       new_data_valid // key led
);
	logic                       sample_tick;
	logic [ir_rx_pkg::N_CH-1:0] ir_level;

	ir_key_if   key_if [ir_rx_pkg::N_CH] (); // decoder -> arbiter
	lcd_char_if chr_if ();                   // arbiter -> lcd

	ir_sampler #(
		.TICK_DIV (TICK_DIV)
	) sampler_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.irda_rxd    (irda_rxd),
		.sample_tick (sample_tick),
		.ir_level    (ir_level)
	);

	for (genvar g = 0; g < ir_rx_pkg::N_CH; g++) begin : g_dec
		ir_nec_decoder dec_i (
			.clk         (clk),
			.arst_n      (arst_n),
			.sample_tick (sample_tick), // shared tick
			.ir_level    (ir_level[g]),
			.key         (key_if[g])
		);
	end

	key_arbiter arb_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.keys           (key_if),
		.chr            (chr_if),
		.new_data_valid (new_data_valid)
	);

	lcd_ctrl lcd_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.lcd_on     (lcd_on),
		.chr        (chr_if),
		.lcd_data   (lcd_data),
		.lcd_en     (lcd_en),
		.lcd_rw     (lcd_rw),
		.lcd_rs     (lcd_rs),
		.lcd_out_on (lcd_out_on)
	);

endmodule

// ==== hdl/ir_nec_decoder.sv ====
`timescale 1ns/1ps

module ir_nec_decoder (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  sample_tick, // 1/8 nec unit
	input  logic  ir_level,    // filtered, low = mark
	ir_key_if.src key
);
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LEAD_MARK,
		ST_LEAD_SPACE,
		ST_BIT_MARK,
		ST_BIT_SPACE,
		ST_STOP_MARK,
		ST_HOLD
	} state_t;

	state_t                           state;
	logic [ir_rx_pkg::TICK_CNT_W-1:0] cnt;       // ticks in current level
	logic [ir_rx_pkg::TICK_CNT_W-1:0] cnt_inc;   // saturating
	logic [4:0]                       bit_cnt;
	logic [31:0]                      shreg;     // lsb first
	logic                             rpt;       // current frame is a repeat code
	logic                             have_last; // last_* valid for repeats
	logic [7:0]                       last_addr;
	logic [7:0]                       last_cmd;
	logic                             mark;
	logic                             bit_end;
	logic                             stop_end;
	logic                             frame_ok;
	logic                             emit;
	logic                             out_free;

	assign mark     = !ir_level;
	assign cnt_inc  = (&cnt) ? cnt : cnt + 1'b1;
	assign bit_end  = sample_tick && (state == ST_BIT_SPACE) && mark;
	assign stop_end = sample_tick && (state == ST_STOP_MARK) && !mark;
	// addr, ~addr, cmd, ~cmd
	assign frame_ok = (shreg[7:0] == ~shreg[15:8]) && (shreg[23:16] == ~shreg[31:24]);
	assign emit     = stop_end && (rpt ? have_last : frame_ok);
	assign out_free = !key.valid || key.ready; // otherwise the new frame is dropped

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			cnt       <= '0;
			bit_cnt   <= '0;
			rpt       <= 1'b0;
			have_last <= 1'b0;
			key.valid <= 1'b0;
		end else begin
			if (key.valid && key.ready)
				key.valid <= 1'b0;
			if (emit && out_free)
				key.valid <= 1'b1;
			if (stop_end && !rpt && frame_ok)
				have_last <= 1'b1;
			if (sample_tick) begin
				case (state)
					ST_IDLE: begin
						have_last <= 1'b0; // only reached by abort or timeout
						if (mark) begin
							state <= ST_LEAD_MARK;
							cnt   <= 1;
						end
					end
					ST_LEAD_MARK: begin
						if (mark) begin
							cnt <= cnt_inc;
						end else if (cnt >= ir_rx_pkg::LEADER_MARK_MIN &&
						             cnt <= ir_rx_pkg::LEADER_MARK_MAX) begin
							state <= ST_LEAD_SPACE;
							cnt   <= 1;
						end else begin
							state <= ST_IDLE;
						end
					end
					ST_LEAD_SPACE: begin
						if (!mark) begin
							cnt <= cnt_inc;
							if (cnt > ir_rx_pkg::LEADER_SPACE_MAX)
								state <= ST_IDLE;
						end else if (cnt >= ir_rx_pkg::LEADER_SPACE_MIN) begin
							state   <= ST_BIT_MARK; // full frame follows
							cnt     <= 1;
							bit_cnt <= '0;
						end else if (cnt >= ir_rx_pkg::REPEAT_SPACE_MIN &&
						             cnt <= ir_rx_pkg::REPEAT_SPACE_MAX) begin
							state <= ST_STOP_MARK; // repeat code, only a stop mark left
							cnt   <= 1;
							rpt   <= 1'b1;
						end else begin
							state <= ST_IDLE;
						end
					end
					ST_BIT_MARK: begin
						if (mark) begin
							cnt <= cnt_inc;
							if (cnt > ir_rx_pkg::BIT_MARK_MAX)
								state <= ST_IDLE;
						end else begin
							state <= ST_BIT_SPACE;
							cnt   <= 1;
						end
					end
					ST_BIT_SPACE: begin
						if (!mark) begin
							cnt <= cnt_inc;
							if (cnt > ir_rx_pkg::BIT_SPACE_MAX)
								state <= ST_IDLE;
						end else begin
							cnt     <= 1;
							bit_cnt <= bit_cnt + 1'b1;
							rpt     <= 1'b0;
							state   <= (bit_cnt == 5'd31) ? ST_STOP_MARK : ST_BIT_MARK;
						end
					end
					ST_STOP_MARK: begin
						if (mark) begin
							cnt <= cnt_inc;
							if (cnt > ir_rx_pkg::BIT_MARK_MAX)
								state <= ST_IDLE;
						end else begin
							state <= (rpt || frame_ok) ? ST_HOLD : ST_IDLE;
							cnt   <= 1;
						end
					end
					ST_HOLD: begin
						if (mark) begin
							state <= ST_LEAD_MARK; // maybe a repeat code
							cnt   <= 1;
						end else if (&cnt) begin
							state <= ST_IDLE; // too late for a repeat
						end else begin
							cnt <= cnt_inc;
						end
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bit_end)
			shreg <= {(cnt > ir_rx_pkg::BIT_SPACE_SPLIT), shreg[31:1]};
		if (stop_end && !rpt && frame_ok) begin
			last_addr <= shreg[7:0];
			last_cmd  <= shreg[23:16];
		end
		if (emit && out_free) begin
			key.addr      <= rpt ? last_addr : shreg[7:0];
			key.cmd       <= rpt ? last_cmd : shreg[23:16];
			key.is_repeat <= rpt;
		end
	end

	// pending key holds until the arbiter takes it
	a_key_hold: assert property (@(posedge clk) disable iff (!arst_n)
		key.valid && !key.ready |=> key.valid && $stable({key.addr, key.cmd, key.is_repeat}));

endmodule

// ==== hdl/ir_rx_pkg.sv ====
package ir_rx_pkg;

	localparam int N_CH = 4; // ir receiver channels

	// tick counter wide enough to span the gap between a frame and its repeat code
	localparam int TICK_CNT_W = 10;

	// nec windows in sample ticks, one tick = 1/8 nec unit
	localparam int LEADER_MARK_MIN  = 112; // nominal 128, 9 ms
	localparam int LEADER_MARK_MAX  = 144;
	localparam int LEADER_SPACE_MIN = 56;  // nominal 64, 4.5 ms
	localparam int LEADER_SPACE_MAX = 72;
	localparam int REPEAT_SPACE_MIN = 24;  // nominal 32, 2.25 ms
	localparam int REPEAT_SPACE_MAX = 40;
	localparam int BIT_MARK_MAX     = 12;  // nominal 8
	localparam int BIT_SPACE_SPLIT  = 16;  // zero 8, one 24
	localparam int BIT_SPACE_MAX    = 32;  // longer aborts the frame

	// lcd strobe timing in clk cycles
	localparam int LCD_EN_CYCLES         = 8;   // enable high width
	localparam int LCD_WAIT_CYCLES       = 32;  // gap after ordinary write
	localparam int LCD_CLEAR_WAIT_CYCLES = 128; // gap after clear

	// hd44780 commands
	localparam logic [7:0] LCD_CLEAR_CMD  = 8'h01;
	localparam logic [7:0] LCD_LINE1_ADDR = 8'h80; // ddram 0x00
	localparam logic [7:0] LCD_LINE2_ADDR = 8'hC0; // ddram 0x40

	localparam int LCD_INIT_LEN = 4;

	// power-up order, index 0 first
	localparam logic [0:LCD_INIT_LEN-1][7:0] LCD_INIT_SEQ = {
		8'h38, // function set, 8 bit, 2 lines
		8'h0C, // display on, cursor off
		8'h01, // clear
		8'h06  // entry mode, increment
	};

	localparam int LCD_COLS = 16; // columns per line

endpackage

// ==== hdl/ir_sampler.sv ====
`timescale 1ns/1ps

module ir_sampler #(
	parameter int TICK_DIV = 4 // clk cycles per sample tick
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [ir_rx_pkg::N_CH-1:0] irda_rxd,    // raw receiver pins, low = mark
	output logic                       sample_tick, // 1 cycle every TICK_DIV
	output logic [ir_rx_pkg::N_CH-1:0] ir_level     // filtered level
);
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0]           div_cnt;
	logic                       div_wrap;
	logic [ir_rx_pkg::N_CH-1:0] sync_q1;
	logic [ir_rx_pkg::N_CH-1:0] sync_q2;
	logic [ir_rx_pkg::N_CH-1:0] hist_q0; // newest filtered sample
	logic [ir_rx_pkg::N_CH-1:0] hist_q1; // one tick older

	assign div_wrap = (div_cnt == CNT_W'(TICK_DIV - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt     <= '0;
			sample_tick <= 1'b0;
		end else begin
			sample_tick <= div_wrap;
			div_cnt     <= div_wrap ? '0 : div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q1  <= '1; // idle line is high
			sync_q2  <= '1;
			hist_q0  <= '1;
			hist_q1  <= '1;
			ir_level <= '1;
		end else begin
			sync_q1 <= irda_rxd;
			sync_q2 <= sync_q1;
			if (sample_tick) begin
				hist_q0  <= sync_q2;
				hist_q1  <= hist_q0;
				// 2 of 3 vote, single-tick glitch is lost
				ir_level <= (sync_q2 & hist_q0) | (sync_q2 & hist_q1) | (hist_q0 & hist_q1);
			end
		end
	end

endmodule

// ==== hdl/key_arbiter.sv ====
`timescale 1ns/1ps

module key_arbiter (
	input  logic    clk,
	input  logic    arst_n,
	ir_key_if.dst   keys [ir_rx_pkg::N_CH],
	lcd_char_if.src chr,
	output logic    new_data_valid // 1 cycle per new character
);
	localparam int IDX_W = $clog2(ir_rx_pkg::N_CH);

	logic [ir_rx_pkg::N_CH-1:0] key_valid;
	logic [ir_rx_pkg::N_CH-1:0] key_ready;
	logic [ir_rx_pkg::N_CH-1:0] key_rpt;
	logic [7:0]                 key_cmd [ir_rx_pkg::N_CH];
	logic [IDX_W-1:0]           rr_ptr;  // first channel to look at
	logic [IDX_W-1:0]           cand;
	logic [IDX_W-1:0]           gnt_idx;
	logic                       gnt_found;
	logic                       accept;
	logic                       slot_full;
	logic [7:0]                 slot_char;

	function automatic logic [7:0] key_to_char(input logic [7:0] cmd);
		case (cmd) inside
			8'h00:          return 8'h00;
			[8'h01:8'h09]:  return 8'h60 + cmd; // 'a'..'i'
			default:        return 8'h20;       // unknown key shows a blank
		endcase
	endfunction

	for (genvar g = 0; g < ir_rx_pkg::N_CH; g++) begin : g_key
		assign key_valid[g]  = keys[g].valid;
		assign key_rpt[g]    = keys[g].is_repeat;
		assign key_cmd[g]    = keys[g].cmd;
		assign keys[g].ready = key_ready[g];
	end

	always_comb begin
		gnt_found = 1'b0;
		gnt_idx   = rr_ptr;
		cand      = rr_ptr;
		for (int k = 0; k < ir_rx_pkg::N_CH; k++) begin
			cand = IDX_W'((int'(rr_ptr) + k) % ir_rx_pkg::N_CH);
			if (!gnt_found && key_valid[cand]) begin
				gnt_found = 1'b1;
				gnt_idx   = cand;
			end
		end
	end

	assign accept = gnt_found && !slot_full; // only into an empty slot

	always_comb begin
		key_ready          = '0;
		key_ready[gnt_idx] = accept;
	end

	assign chr.valid  = slot_full;
	assign chr.code   = slot_char;
	assign chr.is_cmd = 1'b0; // characters only

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rr_ptr         <= '0;
			slot_full      <= 1'b0;
			new_data_valid <= 1'b0;
		end else begin
			new_data_valid <= accept && !key_rpt[gnt_idx];
			if (accept)
				rr_ptr <= IDX_W'((int'(gnt_idx) + 1) % ir_rx_pkg::N_CH);
			if (accept && !key_rpt[gnt_idx])
				slot_full <= 1'b1; // repeats are taken and thrown away
			else if (chr.valid && chr.ready)
				slot_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			slot_char <= key_to_char(key_cmd[gnt_idx]);
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(key_ready) && ((key_ready & ~key_valid) == '0));

endmodule

// ==== hdl/lcd_char_if.sv ====
`timescale 1ns/1ps

interface lcd_char_if;
	logic       valid;
	logic       ready;
	logic [7:0] code;   // character or command byte
	logic       is_cmd; // 1 = command, rs low

	modport src (
		output valid,
		output code,
		output is_cmd,
		input  ready
	);

	modport dst (
		input  valid,
		input  code,
		input  is_cmd,
		output ready
	);
endinterface

// ==== hdl/lcd_ctrl.sv ====
`timescale 1ns/1ps

module lcd_ctrl (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       lcd_on,     // panel power button
	lcd_char_if.dst    chr,
	output logic [7:0] lcd_data,
	output logic       lcd_en,
	output logic       lcd_rw,     // write only
	output logic       lcd_rs,     // 0 = command, 1 = data
	output logic       lcd_out_on  // panel power
);
	localparam int CNT_W = $clog2(ir_rx_pkg::LCD_CLEAR_WAIT_CYCLES + ir_rx_pkg::LCD_EN_CYCLES + 1);
	localparam int CUR_W = $clog2(2 * ir_rx_pkg::LCD_COLS);
	localparam int IDX_W = $clog2(ir_rx_pkg::LCD_INIT_LEN + 1);

	typedef enum logic [2:0] {
		ST_OFF,   // panel off, or first cycle of power-up
		ST_NEXT,  // pick next byte
		ST_IDLE,
		ST_SETUP, // data set up, en low
		ST_EN,
		ST_GAP
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] gap_last;
	logic [IDX_W-1:0] init_idx;
	logic [CUR_W-1:0] cursor;     // 0..31 over both lines
	logic [CUR_W-1:0] cursor_nxt;
	logic             wrapped;    // cursor has passed the end once
	logic             need_addr;
	logic             long_wait;  // clear in flight
	logic             char_pend;  // char waits behind an address command
	logic [7:0]       char_buf;

	assign cursor_nxt = (cursor == CUR_W'(2 * ir_rx_pkg::LCD_COLS - 1)) ? '0 : cursor + 1'b1;
	assign need_addr  = (cursor == CUR_W'(ir_rx_pkg::LCD_COLS)) || (cursor == '0 && wrapped);
	assign gap_last   = long_wait ? CNT_W'(ir_rx_pkg::LCD_CLEAR_WAIT_CYCLES - 1)
	                              : CNT_W'(ir_rx_pkg::LCD_WAIT_CYCLES - 1);
	assign chr.ready  = (state == ST_IDLE) || (state == ST_OFF && !lcd_on); // off drops chars
	assign lcd_rw     = 1'b0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_OFF;
			cnt        <= '0;
			init_idx   <= '0;
			cursor     <= '0;
			wrapped    <= 1'b0;
			long_wait  <= 1'b0;
			char_pend  <= 1'b0;
			lcd_data   <= '0;
			lcd_rs     <= 1'b0;
			lcd_en     <= 1'b0;
			lcd_out_on <= 1'b0;
		end else begin
			lcd_out_on <= lcd_on;
			if (!lcd_on) begin
				state     <= ST_OFF;
				lcd_en    <= 1'b0;
				char_pend <= 1'b0;
			end else begin
				case (state)
					ST_OFF: begin // power-up, replay init
						init_idx <= '0;
						cursor   <= '0;
						wrapped  <= 1'b0;
						state    <= ST_NEXT;
					end
					ST_NEXT: begin
						if (init_idx < IDX_W'(ir_rx_pkg::LCD_INIT_LEN)) begin
							lcd_data  <= ir_rx_pkg::LCD_INIT_SEQ[init_idx];
							lcd_rs    <= 1'b0;
							long_wait <= (ir_rx_pkg::LCD_INIT_SEQ[init_idx] == ir_rx_pkg::LCD_CLEAR_CMD);
							init_idx  <= init_idx + 1'b1;
							state     <= ST_SETUP;
						end else if (char_pend) begin
							lcd_data  <= char_buf;
							lcd_rs    <= 1'b1;
							long_wait <= 1'b0;
							char_pend <= 1'b0;
							cursor    <= cursor_nxt;
							if (cursor_nxt == '0)
								wrapped <= 1'b1;
							state     <= ST_SETUP;
						end else begin
							state <= ST_IDLE;
						end
					end
					ST_IDLE: begin
						if (chr.valid) begin
							state     <= ST_SETUP;
							long_wait <= chr.is_cmd && (chr.code == ir_rx_pkg::LCD_CLEAR_CMD);
							if (chr.is_cmd) begin
								lcd_data <= chr.code;
								lcd_rs   <= 1'b0;
							end else if (need_addr) begin // line change first
								lcd_data  <= wrapped && cursor == '0 ? ir_rx_pkg::LCD_LINE1_ADDR
								                                     : ir_rx_pkg::LCD_LINE2_ADDR;
								lcd_rs    <= 1'b0;
								char_pend <= 1'b1;
							end else begin
								lcd_data <= chr.code;
								lcd_rs   <= 1'b1;
								cursor   <= cursor_nxt;
								if (cursor_nxt == '0)
									wrapped <= 1'b1;
							end
						end
					end
					ST_SETUP: begin
						lcd_en <= 1'b1;
						cnt    <= '0;
						state  <= ST_EN;
					end
					ST_EN: begin
						if (cnt == CNT_W'(ir_rx_pkg::LCD_EN_CYCLES - 1)) begin
							lcd_en <= 1'b0; // panel latches on this fall
							cnt    <= '0;
							state  <= ST_GAP;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					ST_GAP: begin
						if (cnt == gap_last)
							state <= ST_NEXT;
						else
							cnt <= cnt + 1'b1;
					end
					default: state <= ST_OFF;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && chr.valid && !chr.is_cmd && need_addr)
			char_buf <= chr.code;
	end

	a_bus_stable: assert property (@(posedge clk) disable iff (!arst_n)
		lcd_en |-> $stable(lcd_data) && $stable(lcd_rs));

endmodule

// ==== tb.f ====
hdl/ir_rx_pkg.sv
hdl/ir_key_if.sv
hdl/lcd_char_if.sv
hdl/ir_sampler.sv
hdl/ir_nec_decoder.sv
hdl/key_arbiter.sv
hdl/lcd_ctrl.sv
hdl/ir_lcd_top.sv
dv/ir_lcd_tb.sv
